/* Makefile */
# Verilator build and run for the cache subsystem
VERILATOR ?= verilator
TOP ?= cache_tb
FILELIST ?= src.f
OBJ_DIR ?= obj_dir
LOG ?= sim.log
TIMESCALE ?= 1ns/1ps
VFLAGS ?= --binary --timing --assert --timescale $(TIMESCALE)
LINT_FLAGS ?= --lint-only --timing --assert --timescale $(TIMESCALE)
SIM_ARGS ?= +verilator+error+limit+1000
FAIL_MSG ?= RESULT: FAIL
PASS_MSG ?= RESULT: PASS

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)

run: build
	./$(OBJ_DIR)/V$(TOP) $(SIM_ARGS) > $(LOG) 2>&1; \
	status=$$?; \
	cat $(LOG); \
	if grep -q "$(FAIL_MSG)" $(LOG); then echo "simulation failed, see $(LOG)"; exit 1; fi; \
	if ! grep -q "$(PASS_MSG)" $(LOG); then echo "simulation ended early, see $(LOG)"; exit 1; fi; \
	exit $$status

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

/* cache_checker.sv */
// cache protocol checker: request handshake, memory strobes and response timing
`timescale 1ns/1ps
`include "cache_macros.svh"

module cache_checker (
	input logic clk,
	input logic rst,
	input logic req,
	input logic busy,
	input logic rsp_valid,
	input cache_pkg::mem_req_t mem_req,
	input cache_pkg::mem_rsp_t mem_rsp
);
	localparam int LAT = `MEM_LAT; // memory read latency in cycles

	int unsigned fail_cnt = 0; // read by the testbench at the end

	// processor holds off while the cache is busy
	a_req_not_busy: assert property (@(posedge clk) disable iff (rst) req |-> !busy)
		else begin
			fail_cnt++;
			$error("request strobe while busy");
		end

	// one strobe kind per cycle towards memory
	a_rd_wr_excl: assert property (@(posedge clk) disable iff (rst) !(mem_req.rd && mem_req.wr))
		else begin
			fail_cnt++;
			$error("memory read and write strobes together");
		end

	a_rsp_single: assert property (@(posedge clk) disable iff (rst) rsp_valid |=> !rsp_valid)
		else begin
			fail_cnt++;
			$error("response valid held for two cycles");
		end

	// every rd comes back exactly LAT cycles later
	a_rd_returns: assert property (@(posedge clk) disable iff (rst) mem_req.rd |-> ##LAT mem_rsp.valid)
		else begin
			fail_cnt++;
			$error("memory read not returned after fixed latency");
		end

	// and nothing comes back that was not asked for
	a_rsp_has_rd: assert property (@(posedge clk) disable iff (rst)
		mem_rsp.valid |-> $past(mem_req.rd, LAT))
		else begin
			fail_cnt++;
			$error("memory response without a matching read");
		end

endmodule

bind cache_sys cache_checker u_checker (
	.clk(clk),
	.rst(rst),
	.req(req),
	.busy(busy),
	.rsp_valid(rsp_valid),
	.mem_req(mem_req),
	.mem_rsp(mem_rsp)
);

/* cache_fill_fsm.sv */
// cache fill FSM handling hit service, write-through, miss detection and pipelined block fill
`timescale 1ns/1ps
`include "cache_macros.svh"

module cache_fill_fsm (
	input logic clk,
	input logic rst,
	input logic req, // one cycle strobe sent only while not busy
	input cache_pkg::cpu_req_t req_data,
	input logic hit, // from the tag compare in icache
	input cache_pkg::word_t rdata, // data array read
	output cache_pkg::addr_t cache_addr, // address into both arrays
	output logic tag_write,
	output logic data_write,
	output cache_pkg::word_t data_wdata,
	output logic busy, // processor must hold off
	output logic rsp_valid,
	output cache_pkg::word_t rsp_data,
	output cache_pkg::mem_req_t mem_req,
	input cache_pkg::mem_rsp_t mem_rsp
);
	import cache_pkg::*;

	fill_state_e state, nxt_state;
	cpu_req_t cur; // request being served
	offset_t iss_cnt; // next fill word to request
	offset_t ret_cnt; // next fill word to come back
	logic iss_done; // all eight reads sent
	word_t rsp_q;
	logic wr_hit;
	logic last_ret;
	addr_t blk_addr; // block base of the request

	assign blk_addr = {cur.addr[`ADDR_W-1:`OFFSET_W+1], {(`OFFSET_W+1){1'b0}}};
	assign wr_hit = (state == LOOKUP) && hit && cur.wrt; // cache and memory written together
	assign last_ret = mem_rsp.valid && (ret_cnt == offset_t'(`BLOCK_WORDS-1));

	always_ff @(posedge clk) begin
		if (rst) state <= IDLE;
		else state <= nxt_state;
	end

	always_comb begin
		nxt_state = state;
		case (state)
			IDLE: if (req) nxt_state = LOOKUP;
			LOOKUP: nxt_state = hit ? FINISH : FILL; // second lookup after a fill always hits
			FILL: if (last_ret) nxt_state = TAG_WRITE;
			TAG_WRITE: nxt_state = LOOKUP;
			FINISH: nxt_state = IDLE;
			default: nxt_state = IDLE;
		endcase
	end

	// request latch for the payload only
	always_ff @(posedge clk) begin
		if (req && (state == IDLE)) cur <= req_data;
	end

	// issue and return counters run apart so up to MEM_LAT reads overlap
	always_ff @(posedge clk) begin
		if (rst) begin
			iss_cnt <= '0;
			ret_cnt <= '0;
			iss_done <= 1'b0;
		end else if ((state == LOOKUP) && !hit) begin
			iss_cnt <= '0; // a miss arms a new fill
			ret_cnt <= '0;
			iss_done <= 1'b0;
		end else if (state == FILL) begin
			if (!iss_done) begin
				iss_cnt <= iss_cnt + offset_t'(1);
				if (iss_cnt == offset_t'(`BLOCK_WORDS-1)) iss_done <= 1'b1;
			end
			if (mem_rsp.valid) ret_cnt <= ret_cnt + offset_t'(1);
		end
	end

	// response word that returns the written data on a write
	always_ff @(posedge clk) begin
		if ((state == LOOKUP) && hit) rsp_q <= cur.wrt ? cur.wdata : rdata;
	end

	assign rsp_valid = (state == FINISH);
	assign rsp_data = rsp_q;
	assign busy = (state != IDLE); // high from the cycle after req through the response

	// array side
	always_comb begin
		cache_addr = cur.addr;
		if (state == FILL) cache_addr = blk_addr | addr_t'({ret_cnt, 1'b0}); // word coming back
	end
	assign data_write = wr_hit || ((state == FILL) && mem_rsp.valid);
	assign data_wdata = (state == FILL) ? mem_rsp.data : cur.wdata;
	assign tag_write = (state == TAG_WRITE);

	// memory side
	always_comb begin
		mem_req.rd = (state == FILL) && !iss_done;
		mem_req.wr = wr_hit;
		mem_req.addr = mem_req.rd ? (blk_addr | addr_t'({iss_cnt, 1'b0})) : cur.addr;
		mem_req.wdata = cur.wdata;
	end

endmodule

/* cache_macros.svh */
// cache macros: global widths, cache geometry and memory timing
`ifndef CACHE_MACROS_SVH
`define CACHE_MACROS_SVH

// processor side widths
`define ADDR_W 16 // byte address, bit 0 always zero
`define WORD_W 16 // halfword data

// address split: tag 15:11, index 10:4, word offset 3:1
`define TAG_W 5
`define INDEX_W 7 // 128 blocks, direct mapped
`define OFFSET_W 3

// words per cache block
`define BLOCK_WORDS 8

// main memory model
`define MEM_LAT 4 // cycles from rd strobe to returned word
`define MEM_WORDS 32768 // depth in words, indexed by addr[15:1]

`endif

/* cache_pkg.sv */
// cache package: address field types, bus structs and the fill FSM states
`include "cache_macros.svh"

package cache_pkg;

	// vectors with a meaning of their own
	typedef logic [`ADDR_W-1:0] addr_t; // byte address
	typedef logic [`WORD_W-1:0] word_t; // data word
	typedef logic [`TAG_W-1:0] tag_t;
	typedef logic [`INDEX_W-1:0] index_t;
	typedef logic [`OFFSET_W-1:0] offset_t; // word within a block

	// one meta array entry, 6 bits
	typedef struct packed {
		logic valid; // block holds live data
		tag_t tag;
	} meta_t;

	// processor request, 33 bits
	typedef struct packed {
		logic wrt; // high for a write
		addr_t addr;
		word_t wdata;
	} cpu_req_t;

	// strobe to memory, rd and wr never together
	typedef struct packed {
		logic rd;
		logic wr;
		addr_t addr;
		word_t wdata;
	} mem_req_t;

	typedef struct packed {
		logic valid; // one cycle per returned word
		word_t data;
	} mem_rsp_t;

	// fill controller states
	typedef enum logic [2:0] {
		IDLE,
		LOOKUP, // tag compare and data read
		FILL, // block fetch from memory
		TAG_WRITE,
		FINISH // response presented
	} fill_state_e;

endpackage

/* cache_sys.sv */
// cache subsystem top: cache in front of the main memory model
`timescale 1ns/1ps

module cache_sys (
	input logic clk,
	input logic rst,
	input logic req,
	input cache_pkg::cpu_req_t req_data,
	output logic busy,
	output logic rsp_valid,
	output cache_pkg::word_t rsp_data
);
	import cache_pkg::*;

	mem_req_t mem_req; // cache to memory strobes
	mem_rsp_t mem_rsp; // returning fill words

	icache u_cache (
		.clk(clk),
		.rst(rst),
		.req(req),
		.req_data(req_data),
		.busy(busy),
		.rsp_valid(rsp_valid),
		.rsp_data(rsp_data),
		.mem_req(mem_req),
		.mem_rsp(mem_rsp)
	);

	mem_model u_mem (
		.clk(clk),
		.rst(rst),
		.mem_req(mem_req),
		.mem_rsp(mem_rsp)
	);

endmodule

/* cache_tb.sv */
// cache testbench driving directed and LFSR requests against a shadow memory reference
`timescale 1ns/1ps

module cache_tb;
	import cache_pkg::*;

	localparam int SHADOW_WORDS = 32768; // word addressed by addr[15:1]
	localparam logic [15:0] INIT_XOR = 16'h5a3c; // memory fill rule
	localparam int CLK_HALF = 10; // 20 ns period
	localparam int DRIVE_DLY = 2; // inputs change this long after the edge
	localparam int RST_CYCLES = 16;
	localparam int WAIT_LIMIT = 200; // far more cycles than a miss takes
	localparam int RAND_OPS = 400;

	// latency class of a queued expectation
	localparam int LAT_ANY = 0;
	localparam int LAT_HIT = 1; // exactly two cycles
	localparam int LAT_MISS = 2; // more than two cycles

	logic clk;
	logic rst;
	logic req;
	cpu_req_t req_data;
	logic busy;
	logic rsp_valid;
	word_t rsp_data;

	word_t shadow [SHADOW_WORDS]; // what memory must hold
	word_t exp_data_q [$];
	int exp_cyc_q [$]; // cycle of the req strobe
	int exp_lat_q [$];
	addr_t exp_addr_q [$];
	int unsigned cyc = 0;
	int unsigned errors = 0;
	int unsigned n_req = 0;
	int unsigned n_rsp = 0;
	logic [31:0] lfsr;
	logic hung = 1'b0; // set when a wait runs out so no more requests go out

	initial begin
		clk = 1'b0;
		forever #CLK_HALF clk = ~clk;
	end

	always @(posedge clk) cyc <= cyc + 1;

	cache_sys dut (
		.clk(clk),
		.rst(rst),
		.req(req),
		.req_data(req_data),
		.busy(busy),
		.rsp_valid(rsp_valid),
		.rsp_data(rsp_data)
	);

	// right shifting galois LFSR with taps 32 30 26 25
	function automatic logic [31:0] lfsr_next(input logic [31:0] s);
		logic [31:0] n;
		n = s >> 1;
		if (s[0]) n = n ^ 32'ha3000000;
		return n;
	endfunction

	// one LFSR step per bit taken
	task automatic take_bits(input int n, output logic [31:0] bits);
		bits = '0;
		for (int i = 0; i < n; i++) begin
			lfsr = lfsr_next(lfsr);
			bits = {bits[30:0], lfsr[0]};
		end
	endtask

	// expected response is the written word on a write and the shadow copy on a read
	function automatic word_t expected_rsp(input cpu_req_t r);
		if (r.wrt) return r.wdata;
		return shadow[r.addr[15:1]];
	endfunction

	// hot blocks of the random run where the first two share index 0x23
	function automatic addr_t hot_base(input logic [1:0] sel);
		case (sel)
			2'd0: return 16'h1230;
			2'd1: return 16'h9a30;
			2'd2: return 16'h4560;
			default: return 16'hfff0;
		endcase
	endfunction

	// wait for busy low, queue the expectation and pulse req for one cycle
	task automatic issue(input logic wrt, input addr_t addr, input word_t wdata, input int lat);
		cpu_req_t r;
		int waited;
		if (hung) return;
		r.wrt = wrt;
		r.addr = addr;
		r.wdata = wdata;
		waited = 0;
		while (busy && waited < WAIT_LIMIT) begin
			@(posedge clk);
			#DRIVE_DLY;
			waited++;
		end
		if (busy) begin
			$display("ERROR at %0t: busy stuck high, request to %h never sent", $time, addr);
			errors++;
			hung = 1'b1;
			return;
		end
		exp_data_q.push_back(expected_rsp(r));
		exp_cyc_q.push_back(int'(cyc));
		exp_lat_q.push_back(lat);
		exp_addr_q.push_back(addr);
		if (wrt) shadow[addr[15:1]] = wdata; // write-through keeps memory equal to this
		req = 1'b1;
		req_data = r;
		n_req++;
		@(posedge clk);
		#DRIVE_DLY;
		req = 1'b0;
	endtask

	// wait for all outstanding responses
	task automatic drain();
		int waited;
		waited = 0;
		while (exp_data_q.size() != 0 && waited < WAIT_LIMIT) begin
			@(posedge clk);
			waited++;
		end
		if (exp_data_q.size() != 0) begin
			$display("ERROR at %0t: %0d requests were never answered", $time, exp_data_q.size());
			errors++;
			hung = 1'b1;
		end
	endtask

	// compare process sampling mid cycle where the DUT outputs are settled
	always @(negedge clk) begin : compare_rsp
		word_t exp;
		addr_t a;
		int lat;
		int cls;
		logic busy_exp;
		if (!rst) begin
			// busy from the cycle after req up to the response
			busy_exp = (exp_data_q.size() != 0) && !req;
			if (busy !== busy_exp) begin
				$display("FAILED at %0t: busy is %b, expected %b", $time, busy, busy_exp);
				errors++;
			end
		end
		if (!rst && rsp_valid) begin
			n_rsp++;
			if (exp_data_q.size() == 0) begin
				$display("ERROR at %0t: response with no request outstanding", $time);
				errors++;
			end else begin
				exp = exp_data_q.pop_front();
				a = exp_addr_q.pop_front();
				cls = exp_lat_q.pop_front();
				lat = int'(cyc) - exp_cyc_q.pop_front();
				if (rsp_data !== exp) begin
					$display("FAILED at %0t: addr %h returned %h, expected %h",
						$time, a, rsp_data, exp);
					errors++;
				end
				if (cls == LAT_HIT && lat != 2) begin
					$display("FAILED at %0t: addr %h answered after %0d cycles, expected 2",
						$time, a, lat);
					errors++;
				end
				if (cls == LAT_MISS && lat <= 2) begin
					$display("FAILED at %0t: addr %h answered after %0d cycles, expected a miss",
						$time, a, lat);
					errors++;
				end
			end
		end
	end

	initial begin : main_seq
		logic [31:0] bits;
		logic [2:0] off;
		addr_t a;
		word_t d;
		logic wrt;
		rst = 1'b1;
		req = 1'b0;
		req_data = '0;
		lfsr = 32'hcb1c;
		for (int i = 0; i < SHADOW_WORDS; i++) begin
			shadow[i] = word_t'(i) ^ INIT_XOR;
		end
		repeat (RST_CYCLES) @(posedge clk);
		#DRIVE_DLY;
		rst = 1'b0;
		@(posedge clk);
		#DRIVE_DLY;

		// cold reads miss and neighbours in the same block then hit
		issue(1'b0, 16'h0000, '0, LAT_MISS);
		issue(1'b0, 16'h000e, '0, LAT_HIT);
		issue(1'b0, 16'h2a46, '0, LAT_MISS);
		issue(1'b0, 16'h2a40, '0, LAT_HIT);

		// write hit then read back
		issue(1'b1, 16'h000e, 16'hbeef, LAT_HIT);
		issue(1'b0, 16'h000e, '0, LAT_HIT);

		// write miss allocates while the rest of the block keeps memory values
		issue(1'b1, 16'h5c84, 16'h1357, LAT_MISS);
		for (int w = 0; w < 8; w++) begin
			issue(1'b0, 16'h5c80 | addr_t'(w << 1), '0, LAT_HIT);
		end

		// ping pong evictions between two tags on one index
		issue(1'b0, 16'h1234, '0, LAT_MISS);
		issue(1'b1, 16'h1234, 16'hc0de, LAT_HIT);
		issue(1'b0, 16'h9a34, '0, LAT_MISS); // evicts the written block
		issue(1'b0, 16'h1234, '0, LAT_MISS); // refetched from memory
		issue(1'b1, 16'h9a3a, 16'h0f0f, LAT_MISS);
		issue(1'b0, 16'h123a, '0, LAT_MISS);
		issue(1'b0, 16'h9a3a, '0, LAT_MISS);

		// random mix with three in four on the hot blocks and one in four a write
		for (int n = 0; n < RAND_OPS; n++) begin
			take_bits(2, bits);
			if (bits[1:0] != 2'd3) begin
				take_bits(2, bits);
				a = hot_base(bits[1:0]);
				take_bits(3, bits);
				off = bits[2:0];
				a = a | {12'h000, off, 1'b0};
			end else begin
				take_bits(15, bits);
				a = {bits[14:0], 1'b0}; // anywhere in memory
			end
			take_bits(2, bits);
			wrt = (bits[1:0] == 2'd0);
			take_bits(16, bits);
			d = bits[15:0];
			issue(wrt, a, d, LAT_ANY);
		end

		drain();
		repeat (4) @(posedge clk); // room for a stray extra response
		$display("check errors %0d, assertion failures %0d, requests %0d, responses %0d",
			errors, dut.u_checker.fail_cnt, n_req, n_rsp);
		if (errors == 0 && dut.u_checker.fail_cnt == 0 && n_req == n_rsp && !hung) begin
			$display("RESULT: PASS");
		end else begin
			$display("RESULT: FAIL");
		end
		$finish;
	end

endmodule

/* data_array.sv */
// data array: eight halfwords per block, one word written per cycle
`timescale 1ns/1ps
`include "cache_macros.svh"

module data_array (
	input logic clk,
	input cache_pkg::index_t index, // block select
	input cache_pkg::offset_t offset, // word select inside the block
	input logic write,
	input cache_pkg::word_t din,
	output cache_pkg::word_t dout
);
	import cache_pkg::*;

	localparam int NUM_BLOCKS = 1 << `INDEX_W;

	// block by word, 1024 words in all
	word_t words [NUM_BLOCKS][`BLOCK_WORDS];

	// word write on the edge
	// fill words and write hits both land here
	always_ff @(posedge clk) begin
		if (write) begin
			words[index][offset] <= din;
		end
	end

	// read is combinational on index and offset
	assign dout = words[index][offset];

endmodule

/* icache.sv */
// direct mapped write-through cache: address decode, tag compare and storage
`timescale 1ns/1ps
`include "cache_macros.svh"

module icache (
	input logic clk,
	input logic rst,
	input logic req,
	input cache_pkg::cpu_req_t req_data,
	output logic busy,
	output logic rsp_valid,
	output cache_pkg::word_t rsp_data,
	output cache_pkg::mem_req_t mem_req,
	input cache_pkg::mem_rsp_t mem_rsp
);
	import cache_pkg::*;

	addr_t cache_addr; // request address, or the fill word during a miss
	tag_t tag;
	index_t index;
	offset_t offset;
	meta_t meta_rd;
	meta_t meta_wr;
	logic hit;
	logic tag_write;
	logic data_write;
	word_t data_wdata;
	word_t rdata;

	// tag 15:11, index 10:4, offset 3:1, bit 0 unused
	assign tag = cache_addr[`ADDR_W-1 -: `TAG_W];
	assign index = cache_addr[`OFFSET_W+1 +: `INDEX_W];
	assign offset = cache_addr[1 +: `OFFSET_W];

	// the only meta value ever written
	assign meta_wr = '{valid: 1'b1, tag: tag};

	// no hit while the tag is being written
	assign hit = !tag_write && meta_rd.valid && (meta_rd.tag == tag);

	cache_fill_fsm u_fsm (
		.clk(clk),
		.rst(rst),
		.req(req),
		.req_data(req_data),
		.hit(hit),
		.rdata(rdata),
		.cache_addr(cache_addr),
		.tag_write(tag_write),
		.data_write(data_write),
		.data_wdata(data_wdata),
		.busy(busy),
		.rsp_valid(rsp_valid),
		.rsp_data(rsp_data),
		.mem_req(mem_req),
		.mem_rsp(mem_rsp)
	);

	meta_data_array u_meta (
		.clk(clk),
		.rst(rst),
		.index(index),
		.write(tag_write),
		.din(meta_wr),
		.dout(meta_rd)
	);

	data_array u_data (
		.clk(clk),
		.index(index),
		.offset(offset),
		.write(data_write),
		.din(data_wdata),
		.dout(rdata)
	);

endmodule

/* mem_model.sv */
// main memory model: word addressed, fixed latency pipelined reads, one cycle writes
`timescale 1ns/1ps
`include "cache_macros.svh"

module mem_model (
	input logic clk,
	input logic rst,
	input cache_pkg::mem_req_t mem_req,
	output cache_pkg::mem_rsp_t mem_rsp
);
	import cache_pkg::*;

	localparam int WADDR_W = `ADDR_W - 1;

	word_t mem [`MEM_WORDS];
	logic [WADDR_W-1:0] waddr; // word address, addr[15:1]
	logic [`MEM_LAT-1:0] pipe_vld; // read valid per stage
	word_t pipe_data [`MEM_LAT];

	assign waddr = mem_req.addr[`ADDR_W-1:1];

	// known contents, each word holds its own word address xor 5a3c
	initial begin
		for (int i = 0; i < `MEM_WORDS; i++) begin
			mem[i] = word_t'(i) ^ 16'h5a3c;
		end
	end

	always @(posedge clk) begin
		if (mem_req.wr) mem[waddr] <= mem_req.wdata; // write-through from the cache
	end

	// valid shift, one stage per cycle of latency
	always_ff @(posedge clk) begin
		if (rst) pipe_vld <= '0;
		else pipe_vld <= {pipe_vld[`MEM_LAT-2:0], mem_req.rd};
	end

	always_ff @(posedge clk) begin
		if (mem_req.rd) pipe_data[0] <= mem[waddr]; // array read at the strobe
		for (int i = 1; i < `MEM_LAT; i++) begin
			pipe_data[i] <= pipe_data[i-1];
		end
	end

	// last stage, MEM_LAT cycles after the rd strobe
	assign mem_rsp.valid = pipe_vld[`MEM_LAT-1];
	assign mem_rsp.data = pipe_data[`MEM_LAT-1];

endmodule

/* meta_data_array.sv */
// meta data array: valid bit and tag for each of the 128 cache blocks
`timescale 1ns/1ps
`include "cache_macros.svh"

module meta_data_array (
	input logic clk,
	input logic rst,
	input cache_pkg::index_t index, // block select
	input logic write, // tag write strobe
	input cache_pkg::meta_t din,
	output cache_pkg::meta_t dout
);
	import cache_pkg::*;

	localparam int NUM_BLOCKS = 1 << `INDEX_W;

	meta_t entries [NUM_BLOCKS]; // index decode folded into the array

	// reset only drops the valid bits, stale tags are harmless
	always_ff @(posedge clk) begin
		if (rst) begin
			for (int i = 0; i < NUM_BLOCKS; i++) begin
				entries[i].valid <= 1'b0;
			end
		end else if (write) begin
			entries[index] <= din; // only ever written at the end of a fill
		end
	end

	// combinational read so the tag compare fits in the lookup cycle
	assign dout = entries[index];

endmodule

/* src.f */
+incdir+.
cache_pkg.sv
meta_data_array.sv
data_array.sv
cache_fill_fsm.sv
icache.sv
mem_model.sv
cache_sys.sv
cache_checker.sv
cache_tb.sv
